// File: all.f
+incdir+include
logic/raster_pkg.sv
logic/tri_rasterizer.sv
logic/pixel_framebuffer.sv
logic/display_scanout.sv
logic/raster_top.sv
test/raster_checker.sv
test/raster_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= raster_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: test/raster_tb.sv
`timescale 1ns/1ns
`include "raster_settings.svh"

module raster_tb;
    import raster_pkg::*;

    localparam int FB_PIX     = `FB_WIDTH * `FB_HEIGHT;
    localparam int RASTER     = `H_TOTAL * `V_TOTAL;
    localparam int MAX_CYCLES = 40000;          // 8 walks of ~1600 plus 8 frames

    logic     clk_pix = 1'b0;
    logic     rst_n;
    logic     cmd_valid;
    logic     cmd_ready;
    tri_cmd_t cmd;
    logic     done;
    logic     frame;
    pix_out_t pix;

    logic [3:0] model_fb [FB_PIX];              // expected framebuffer contents
    integer     seed = 32'h9c1c;
    int         cycles = 0;
    int         done_count = 0;
    int         frame_req = 0;
    int         frames_done = 0;
    int         errors_cmd = 0;
    int         errors_frame = 0;

    raster_top u_dut (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .done      (done),
        .frame     (frame),
        .pix       (pix)
    );

    bind raster_top raster_checker u_chk (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .wb      (wb),
        .wb_ack  (wb_ack),
        .pix     (pix)
    );

    always #50 clk_pix = ~clk_pix;

    // edge i runs from vertex i to vertex (i+1) mod 3
    function automatic int edge_val(tri_cmd_t c, int i, int x, int y);
        int j;
        j = (i + 1) % 3;
        return (int'(c.v[j].x) - int'(c.v[i].x)) * (y - int'(c.v[i].y))
             - (int'(c.v[j].y) - int'(c.v[i].y)) * (x - int'(c.v[i].x));
    endfunction

    function automatic void ref_fill(tri_cmd_t c);
        int e0, e1, e2;
        logic pos, neg, hit;
        if (c.op == op_fill && edge_val(c, 0, int'(c.v[2].x), int'(c.v[2].y)) == 0)
            return;                             // zero area draws nothing
        for (int y = 0; y < `FB_HEIGHT; y++) begin
            for (int x = 0; x < `FB_WIDTH; x++) begin
                e0 = edge_val(c, 0, x, y);
                e1 = edge_val(c, 1, x, y);
                e2 = edge_val(c, 2, x, y);
                pos = (e0 >= 0) && (e1 >= 0) && (e2 >= 0);
                neg = (e0 <= 0) && (e1 <= 0) && (e2 <= 0);
                hit = (pos || neg) && !(e0 == 0 && e1 == 0 && e2 == 0);
                if (c.op == op_clear || hit) model_fb[y * `FB_WIDTH + x] = c.colour;
            end
        end
    endfunction

    function automatic pix_out_t ref_pixel(int x, int y);
        pix_out_t p;
        int i;
        p = '0;
        p.x = 8'(x);
        p.y = 8'(y);
        p.de = (x < `H_ACTIVE) && (y < `V_ACTIVE);
        if (p.de && x < `FB_WIDTH && y < `FB_HEIGHT) begin
            i = int'(model_fb[y * `FB_WIDTH + x]);
            p.r = 8'(i * 17);
            p.g = 8'((15 - i) * 17);
            p.b = 8'((i ^ 5) * 17);
        end else if (p.de) begin                // active but outside the buffer
            p.r = `BG_R;
            p.g = `BG_G;
            p.b = `BG_B;
        end
        return p;
    endfunction

    function automatic tri_cmd_t make_tri(raster_op_e op, int x0, int y0, int x1, int y1,
                                          int x2, int y2, logic [3:0] colour);
        tri_cmd_t c;
        c.op = op;
        c.colour = colour;
        c.v[0].x = 8'(x0);
        c.v[0].y = 8'(y0);
        c.v[1].x = 8'(x1);
        c.v[1].y = 8'(y1);
        c.v[2].x = 8'(x2);
        c.v[2].y = 8'(y2);
        return c;
    endfunction

    // ccw on screen with y pointing down means negative area
    function automatic tri_cmd_t random_tri(logic ccw, logic [3:0] colour);
        tri_cmd_t c;
        vertex_t t;
        int area;
        c = make_tri(op_fill, 0, 0, 0, 0, 0, 0, colour);
        area = 0;
        while (area == 0) begin
            for (int k = 0; k < 3; k++) begin
                c.v[k].x = 8'({$random(seed)} % `FB_WIDTH);
                c.v[k].y = 8'({$random(seed)} % `FB_HEIGHT);
            end
            area = edge_val(c, 0, int'(c.v[2].x), int'(c.v[2].y));
        end
        if ((area < 0) != ccw) begin
            t = c.v[1];
            c.v[1] = c.v[2];
            c.v[2] = t;
        end
        return c;
    endfunction

    task automatic check_field(string name, int n, logic [7:0] got, logic [7:0] want);
        if (got != want) begin
            $display("CHECK FAILED %s at pixel %0d: got %h expected %h", name, n, got, want);
            errors_frame++;
        end
    endtask

    // called on a rising edge, returns on the edge of the transfer
    task automatic send_cmd(tri_cmd_t c);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk_pix);
        while (!cmd_ready) @(posedge clk_pix);
        cmd_valid <= 1'b0;
    endtask

    task automatic frame_check;
        frame_req = frame_req + 1;
        wait (frames_done == frame_req);
        @(posedge clk_pix);
    endtask

    task automatic run_cmd(tri_cmd_t c);
        int target;
        target = done_count + 1;
        send_cmd(c);
        while (done_count < target) @(posedge clk_pix);
        ref_fill(c);
        frame_check();
    endtask

    always @(posedge clk_pix) begin
        if (done) done_count <= done_count + 1;
    end

    // captures one raster from the frame pulse and compares every field
    always begin
        pix_out_t want;
        wait (frame_req != frames_done);
        @(negedge clk_pix);
        while (!frame) @(negedge clk_pix);
        repeat (2) @(negedge clk_pix);          // pix lags the counters by 2
        for (int n = 0; n < RASTER; n++) begin
            want = ref_pixel(n % `H_TOTAL, n / `H_TOTAL);
            check_field("pix.x", n, pix.x, want.x);
            check_field("pix.y", n, pix.y, want.y);
            check_field("pix.de", n, 8'(pix.de), 8'(want.de));
            check_field("pix.r", n, pix.r, want.r);
            check_field("pix.g", n, pix.g, want.g);
            check_field("pix.b", n, pix.b, want.b);
            check_field("frame", n, 8'(frame), 8'(n == RASTER - 2));
            @(negedge clk_pix);
        end
        frames_done = frames_done + 1;
    end

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run not finished after %0d cycles, errors: %0d",
                     cycles, errors_cmd + errors_frame);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        tri_cmd_t a, b;
        int d0;
        rst_n     <= 1'b0;
        cmd_valid <= 1'b0;
        cmd       <= '0;
        for (int k = 0; k < FB_PIX; k++) model_fb[k] = 4'd0;
        repeat (2) @(posedge clk_pix);
        if (cmd_ready != 1'b1) begin
            $display("CHECK FAILED cmd_ready: got %h expected %h", cmd_ready, 1'b1);
            errors_cmd++;
        end
        if (done != 1'b0) begin
            $display("CHECK FAILED done: got %h expected %h", done, 1'b0);
            errors_cmd++;
        end
        rst_n <= 1'b1;
        for (int k = 0; k < 3; k++) begin       // first pixel lands on the third sample
            @(negedge clk_pix);
            if (pix.de != (k == 2)) begin
                $display("CHECK FAILED pix.de: got %h expected %h", pix.de, k == 2);
                errors_cmd++;
            end
        end
        @(posedge clk_pix);
        run_cmd(make_tri(op_clear, 0, 0, 0, 0, 0, 0, 4'd9));
        run_cmd(random_tri(1'b1, 4'd3));
        run_cmd(random_tri(1'b0, 4'd12));
        run_cmd(make_tri(op_fill, 0, 0, 10, 5, 20, 10, 4'd1));        // collinear
        run_cmd(make_tri(op_fill, -20, -20, -5, -18, -10, -3, 4'd2)); // off-screen
        run_cmd(make_tri(op_fill, -10, -6, 45, 10, 5, 30, 4'd6));     // clipped
        a  = random_tri(1'b1, 4'd14);
        b  = make_tri(op_fill, 3, 20, 30, 2, 28, 22, 4'd5);
        d0 = done_count;
        send_cmd(a);
        send_cmd(b);                            // held while the first one runs
        if (done_count != d0 + 1) begin
            $display("CHECK FAILED done_count: got %h expected %h", done_count, d0 + 1);
            errors_cmd++;
        end
        while (done_count < d0 + 2) @(posedge clk_pix);
        ref_fill(a);
        ref_fill(b);
        frame_check();
        $display("errors: %0d (commands %0d, frames %0d)",
                 errors_cmd + errors_frame, errors_cmd, errors_frame);
        if (errors_cmd + errors_frame == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: test/raster_checker.sv
`timescale 1ns/1ns
`include "raster_settings.svh"

module raster_checker (
    input logic                 clk_pix,
    input logic                 rst_n,
    input raster_pkg::wb_req_t  wb,
    input logic                 wb_ack,
    input raster_pkg::pix_out_t pix
);

    // slave answers only a live request
    ack_needs_req: assert property (@(posedge clk_pix) disable iff (!rst_n)
        wb_ack |-> (wb.cyc && wb.stb))
        else $error("wb_ack high without cyc and stb");

    ack_single: assert property (@(posedge clk_pix) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles in a row");

    // master holds the request until the slave acks
    req_held: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (wb.stb && !wb_ack) |=> (wb.stb && $stable(wb.adr)))
        else $error("stb or adr changed before ack");

    de_in_active: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (int'(pix.x) >= `H_ACTIVE || int'(pix.y) >= `V_ACTIVE) |-> !pix.de)
        else $error("pix.de high outside the active area");

endmodule

// File: logic/raster_top.sv
`timescale 1ns/1ns
`include "raster_settings.svh"

module raster_top (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  raster_pkg::tri_cmd_t cmd,
    output logic                 done,
    output logic                 frame,
    output raster_pkg::pix_out_t pix
);
    import raster_pkg::*;

    wb_req_t              wb;                    // rasteriser to framebuffer
    logic                 wb_ack;
    logic [`FB_ADDRW-1:0] rd_addr;
    logic [`IDXW-1:0]     rd_data;

    tri_rasterizer u_raster (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .wb        (wb),
        .wb_ack    (wb_ack),
        .done      (done)
    );

    pixel_framebuffer u_fb (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .wb      (wb),
        .wb_ack  (wb_ack),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    display_scanout u_scan (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .frame   (frame),
        .pix     (pix)
    );

endmodule

// File: logic/display_scanout.sv
`timescale 1ns/1ns
`include "raster_settings.svh"

module display_scanout (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    output logic [`FB_ADDRW-1:0] rd_addr,
    input  logic [`IDXW-1:0]     rd_data,
    output logic                 frame,
    output raster_pkg::pix_out_t pix
);
    localparam int SW = `SCRW;
    localparam int AW = `FB_ADDRW;
    localparam logic [SW-1:0] H_LAST = SW'(`H_TOTAL - 1);
    localparam logic [SW-1:0] V_LAST = SW'(`V_TOTAL - 1);

    // stage 0
    logic [SW-1:0] sx, sy;
    logic          in_fb0, active0;

    // stage 1, lines up with rd_data
    logic [SW-1:0] x1, y1;
    logic          in_fb1, active1;

    logic [7:0] pal_r, pal_g, pal_b;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    assign in_fb0  = (sx < SW'(`FB_WIDTH)) && (sy < SW'(`FB_HEIGHT));
    assign active0 = (sx < SW'(`H_ACTIVE)) && (sy < SW'(`V_ACTIVE));
    assign frame   = (sx == '0) && (sy == '0);

    // park the address outside the buffer region
    assign rd_addr = in_fb0 ? AW'(sy) * AW'(`FB_WIDTH) + AW'(sx) : '0;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            x1      <= '0;
            y1      <= '0;
            in_fb1  <= 1'b0;
            active1 <= 1'b0;
        end else begin
            x1      <= sx;
            y1      <= sy;
            in_fb1  <= in_fb0;
            active1 <= active0;
        end
    end

    // fixed palette, each nibble times 17 is the nibble doubled
    always_comb begin
        pal_r = {rd_data, rd_data};
        pal_g = {~rd_data, ~rd_data};
        pal_b = {rd_data ^ 4'd5, rd_data ^ 4'd5};
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            pix <= '0;
        end else begin
            pix.x  <= x1;
            pix.y  <= y1;
            pix.de <= active1;
            if (!active1) begin                  // blanking
                pix.r <= '0;
                pix.g <= '0;
                pix.b <= '0;
            end else if (in_fb1) begin
                pix.r <= pal_r;
                pix.g <= pal_g;
                pix.b <= pal_b;
            end else begin
                pix.r <= `BG_R;
                pix.g <= `BG_G;
                pix.b <= `BG_B;
            end
        end
    end

endmodule

// File: logic/pixel_framebuffer.sv
`timescale 1ns/1ns
`include "raster_settings.svh"

module pixel_framebuffer (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    input  raster_pkg::wb_req_t  wb,
    output logic                 wb_ack,
    input  logic [`FB_ADDRW-1:0] rd_addr,
    output logic [`IDXW-1:0]     rd_data
);
    localparam int DEPTH = `FB_WIDTH * `FB_HEIGHT;

    // row-major, y*FB_WIDTH + x
    logic [`IDXW-1:0] mem [DEPTH] = '{default: '0};

    logic take;                                  // new request seen

    assign take = wb.cyc && wb.stb && !wb_ack;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= take;                      // single cycle ack
        end
    end

    // write lands on the same edge that raises ack
    always_ff @(posedge clk_pix) begin
        if (take && wb.we) begin
            mem[wb.adr] <= wb.dat_w;
        end
    end

    // read port sees the old word on a same-address collision
    always_ff @(posedge clk_pix) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: logic/tri_rasterizer.sv
`timescale 1ns/1ns
`include "raster_settings.svh"

module tri_rasterizer (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  raster_pkg::tri_cmd_t cmd,
    output raster_pkg::wb_req_t  wb,
    input  logic                 wb_ack,
    output logic                 done
);
    import raster_pkg::*;

    localparam int EW = `EDGEW;
    localparam int CW = `CORDW;
    localparam int AW = `FB_ADDRW;

    raster_state_e state;
    tri_cmd_t      cmd_q;                        // command latched on accept

    logic [CW-1:0] px, py;                       // current pixel
    logic [CW-1:0] bx0, bx1, by1;                // clipped box
    logic signed [EW-1:0] e_cur  [3];            // edge values at (px, py)
    logic signed [EW-1:0] e_row  [3];            // edge values at (bx0, py)
    logic signed [EW-1:0] step_x [3];
    logic signed [EW-1:0] step_y [3];

    // setup terms from cmd_q
    logic signed [EW-1:0] vx [3];
    logic signed [EW-1:0] vy [3];
    logic signed [EW-1:0] dx [3];
    logic signed [EW-1:0] dy [3];
    logic signed [EW-1:0] e_init [3];
    logic signed [EW-1:0] min_x, max_x, min_y, max_y;
    logic signed [EW-1:0] lo_x, hi_x, lo_y, hi_y;
    logic signed [EW-1:0] area;
    logic skip;                                  // nothing to draw

    logic all_pos, all_neg, all_zero;
    logic covered, last, adv;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            vx[i] = EW'($signed(cmd_q.v[i].x));
            vy[i] = EW'($signed(cmd_q.v[i].y));
        end
        for (int i = 0; i < 3; i++) begin
            dx[i] = vx[(i + 1) % 3] - vx[i];
            dy[i] = vy[(i + 1) % 3] - vy[i];
        end
        min_x = vx[0];
        max_x = vx[0];
        min_y = vy[0];
        max_y = vy[0];
        for (int i = 1; i < 3; i++) begin
            if (vx[i] < min_x) min_x = vx[i];
            if (vx[i] > max_x) max_x = vx[i];
            if (vy[i] < min_y) min_y = vy[i];
            if (vy[i] > max_y) max_y = vy[i];
        end
        // clip to the framebuffer
        lo_x = (min_x < 0) ? '0 : min_x;
        lo_y = (min_y < 0) ? '0 : min_y;
        hi_x = (max_x > EW'(`FB_WIDTH - 1))  ? EW'(`FB_WIDTH - 1)  : max_x;
        hi_y = (max_y > EW'(`FB_HEIGHT - 1)) ? EW'(`FB_HEIGHT - 1) : max_y;
        if (cmd_q.op == op_clear) begin
            lo_x = '0;
            lo_y = '0;
            hi_x = EW'(`FB_WIDTH - 1);
            hi_y = EW'(`FB_HEIGHT - 1);
        end
        for (int i = 0; i < 3; i++) begin
            e_init[i] = dx[i] * (lo_y - vy[i]) - dy[i] * (lo_x - vx[i]);
        end
        area = dx[0] * (vy[2] - vy[0]) - dy[0] * (vx[2] - vx[0]);
        skip = (cmd_q.op == op_fill) &&
               (area == 0 || lo_x > hi_x || lo_y > hi_y);
    end

    // coverage of the current pixel in either winding
    always_comb begin
        all_pos  = 1'b1;
        all_neg  = 1'b1;
        all_zero = 1'b1;
        for (int i = 0; i < 3; i++) begin
            if (e_cur[i] < 0) all_pos = 1'b0;
            if (e_cur[i] > 0) all_neg = 1'b0;
            if (e_cur[i] != 0) all_zero = 1'b0;
        end
        covered = (cmd_q.op == op_clear) || ((all_pos || all_neg) && !all_zero);
    end

    assign last = (px == bx1) && (py == by1);
    assign adv  = (state == st_walk && !covered) || (state == st_write && wb_ack);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:  if (cmd_valid) state <= st_setup;
                st_setup: state <= skip ? st_done : st_walk;
                st_walk: begin
                    if (covered) state <= st_write;
                    else if (last) state <= st_done;
                end
                st_write: if (wb_ack) state <= last ? st_done : st_walk;
                st_done:  state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (cmd_valid && cmd_ready) cmd_q <= cmd;
        if (state == st_setup) begin
            px  <= CW'(lo_x);
            py  <= CW'(lo_y);
            bx0 <= CW'(lo_x);
            bx1 <= CW'(hi_x);
            by1 <= CW'(hi_y);
            for (int i = 0; i < 3; i++) begin
                e_cur[i]  <= e_init[i];
                e_row[i]  <= e_init[i];
                step_x[i] <= -dy[i];
                step_y[i] <= dx[i];
            end
        end else if (adv) begin
            if (px == bx1) begin                 // next row
                px <= bx0;
                py <= py + 1'b1;
                for (int i = 0; i < 3; i++) begin
                    e_row[i] <= e_row[i] + step_y[i];
                    e_cur[i] <= e_row[i] + step_y[i];
                end
            end else begin
                px <= px + 1'b1;
                for (int i = 0; i < 3; i++) begin
                    e_cur[i] <= e_cur[i] + step_x[i];
                end
            end
        end
    end

    // stb rises in the walk cycle and holds until ack
    always_comb begin
        wb.stb   = (state == st_walk && covered) || (state == st_write);
        wb.cyc   = wb.stb;
        wb.we    = wb.stb;
        wb.adr   = AW'(py) * AW'(`FB_WIDTH) + AW'(px);
        wb.dat_w = cmd_q.colour;
    end

    assign cmd_ready = (state == st_idle);
    assign done      = (state == st_done);

endmodule

// File: logic/raster_pkg.sv
`include "raster_settings.svh"

package raster_pkg;

    typedef enum logic {
        op_clear,
        op_fill
    } raster_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_setup,
        st_walk,
        st_write,
        st_done
    } raster_state_e;

    typedef struct packed {
        logic signed [`CORDW-1:0] x;
        logic signed [`CORDW-1:0] y;
    } vertex_t;

    typedef struct packed {
        raster_op_e          op;
        vertex_t [2:0]       v;       // v[0] v[1] v[2]
        logic [`IDXW-1:0]    colour;
    } tri_cmd_t;

    // master to slave half of the wishbone link, ack travels separately
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [`FB_ADDRW-1:0] adr;
        logic [`IDXW-1:0]    dat_w;
    } wb_req_t;

    typedef struct packed {
        logic [`SCRW-1:0]    x;
        logic [`SCRW-1:0]    y;
        logic                de;
        logic [7:0]          r;
        logic [7:0]          g;
        logic [7:0]          b;
    } pix_out_t;

endpackage

// File: include/raster_settings.svh
`ifndef RASTER_SETTINGS_SVH
`define RASTER_SETTINGS_SVH

// framebuffer geometry
`define FB_WIDTH   32
`define FB_HEIGHT  24
`define FB_ADDRW   10           // holds FB_WIDTH*FB_HEIGHT addresses

// display raster, no sync pulses
`define H_ACTIVE   40
`define H_TOTAL    48
`define V_ACTIVE   30
`define V_TOTAL    34

// colour outside the framebuffer region
`define BG_R       8'h11
`define BG_G       8'h33
`define BG_B       8'h77

// widths
`define CORDW      8            // signed vertex coordinate
`define IDXW       4            // colour index per pixel
`define SCRW       8            // raster counter and pix coordinate
`define EDGEW      (2*`CORDW+4) // edge function accumulator

`endif
